//--- source/hist_config.svh
`ifndef HIST_CONFIG_SVH
`define HIST_CONFIG_SVH

// Width of one input sample.
`define HIST_SAMPLE_WIDTH 16

// Bin address bits, taken from the low end of the sample.
`define HIST_ADDR_WIDTH 4

// Width of one bin count; counts saturate at all ones.
`define HIST_COUNT_WIDTH 8

`endif

//--- source/hist_pkg.sv
`include "hist_config.svh"

package hist_pkg;

  // One sample from the input stream.
  typedef logic [`HIST_SAMPLE_WIDTH-1:0] sample_t;

  // One bin address.
  typedef logic [`HIST_ADDR_WIDTH-1:0] bin_t;

  // One bin count.
  typedef logic [`HIST_COUNT_WIDTH-1:0] count_t;

endpackage

//--- source/hist_bin_counter.sv
`include "hist_config.svh"

module hist_bin_counter
(
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              s_valid,
  input  hist_pkg::sample_t s_sample,
  output logic              s_ready,
  output hist_pkg::bin_t    a_addr,
  output hist_pkg::count_t  a_wdata,
  output logic              a_we,
  input  hist_pkg::count_t  a_rdata,
  output logic              clear_done
);

  typedef enum logic [1:0]
  {
    ST_CLEAR,
    ST_IDLE,
    ST_READ_WAIT,
    ST_WRITE
  } state_t;

  state_t           state_reg;
  state_t           state_next;
  hist_pkg::bin_t   clear_addr_reg;
  hist_pkg::bin_t   clear_addr_next;
  logic             clear_done_reg;
  logic             clear_done_next;
  logic             wr_en_reg;
  logic             wr_en_next;
  hist_pkg::bin_t   bin_reg;
  hist_pkg::count_t wdata_reg;
  logic             take;

  assign take = s_valid & s_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_reg      <= ST_CLEAR;
      clear_addr_reg <= '0;
      clear_done_reg <= 1'b0;
      wr_en_reg      <= 1'b0;
    end
    else
    begin
      state_reg      <= state_next;
      clear_addr_reg <= clear_addr_next;
      clear_done_reg <= clear_done_next;
      wr_en_reg      <= wr_en_next;
    end
  end

  // Bin of the sample in flight and the value to write back.
  always_ff @(posedge aclk)
  begin
    if (take)
    begin
      bin_reg <= s_sample[`HIST_ADDR_WIDTH-1:0];
    end
    if (state_reg == ST_READ_WAIT)
    begin
      wdata_reg <= a_rdata + 1'b1;
    end
  end

  always_comb
  begin
    state_next      = state_reg;
    clear_addr_next = clear_addr_reg;
    clear_done_next = clear_done_reg;
    wr_en_next      = wr_en_reg;
    case (state_reg)
      ST_CLEAR:
      begin
        clear_addr_next = clear_addr_reg + 1'b1;
        if (&clear_addr_reg)
        begin
          clear_done_next = 1'b1;
          state_next      = ST_IDLE;
        end
      end
      ST_IDLE:
      begin
        if (take)
        begin
          state_next = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT:
      begin
        // A full bin keeps its value.
        wr_en_next = ~&a_rdata;
        state_next = ST_WRITE;
      end
      ST_WRITE:
      begin
        wr_en_next = 1'b0;
        state_next = ST_IDLE;
      end
      default:
      begin
        state_next = ST_CLEAR;
      end
    endcase
  end

  // Port A address follows the sample directly in idle so the read starts on accept.
  always_comb
  begin
    case (state_reg)
      ST_CLEAR: a_addr = clear_addr_reg;
      ST_IDLE:  a_addr = s_sample[`HIST_ADDR_WIDTH-1:0];
      default:  a_addr = bin_reg;
    endcase
  end

  assign a_we       = (state_reg == ST_CLEAR) | ((state_reg == ST_WRITE) & wr_en_reg);
  assign a_wdata    = (state_reg == ST_CLEAR) ? '0 : wdata_reg;
  assign s_ready    = (state_reg == ST_IDLE);
  assign clear_done = clear_done_reg;

  // A count write never wraps a full bin back to zero.
  a_no_wrap_on_write: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (a_we && clear_done) |-> (a_wdata != '0)
  );

  a_no_ready_before_clear: assert property (
    @(posedge aclk) disable iff (!aresetn)
    !clear_done |-> !s_ready
  );

endmodule

//--- source/hist_dual_port_ram.sv
`include "hist_config.svh"

module hist_dual_port_ram
(
  input  logic             aclk,
  input  hist_pkg::bin_t   a_addr,
  input  hist_pkg::count_t a_wdata,
  input  logic             a_we,
  output hist_pkg::count_t a_rdata,
  input  hist_pkg::bin_t   b_addr,
  output hist_pkg::count_t b_rdata
);

  localparam int DEPTH = 1 << `HIST_ADDR_WIDTH;

  hist_pkg::count_t mem [DEPTH];

  // Port A reads before it writes.
  always_ff @(posedge aclk)
  begin
    if (a_we)
    begin
      mem[a_addr] <= a_wdata;
    end
    a_rdata <= mem[a_addr];
  end

  // Port B is read only.
  always_ff @(posedge aclk)
  begin
    b_rdata <= mem[b_addr];
  end

endmodule

//--- source/hist_readout.sv
`include "hist_config.svh"

module hist_readout
(
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             clear_done,
  input  logic             rd_req_valid,
  input  hist_pkg::bin_t   rd_req_bin,
  output logic             rd_req_ready,
  output hist_pkg::bin_t   b_addr,
  input  hist_pkg::count_t b_rdata,
  output logic             rd_valid,
  output hist_pkg::bin_t   rd_bin,
  output hist_pkg::count_t rd_count,
  input  logic             rd_ready
);

  typedef enum logic [1:0]
  {
    ST_READY,
    ST_WAIT,
    ST_HOLD
  } state_t;

  state_t           state_reg;
  state_t           state_next;
  hist_pkg::bin_t   bin_reg;
  hist_pkg::count_t count_reg;
  logic             req_take;

  assign rd_req_ready = (state_reg == ST_READY) & clear_done;
  assign req_take     = rd_req_valid & rd_req_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_reg <= ST_READY;
    end
    else
    begin
      state_reg <= state_next;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (req_take)
    begin
      bin_reg <= rd_req_bin;
    end
    if (state_reg == ST_WAIT)
    begin
      count_reg <= b_rdata;
    end
  end

  always_comb
  begin
    state_next = state_reg;
    case (state_reg)
      ST_READY:
      begin
        if (req_take)
        begin
          state_next = ST_WAIT;
        end
      end
      ST_WAIT:
      begin
        state_next = ST_HOLD;
      end
      ST_HOLD:
      begin
        if (rd_ready)
        begin
          state_next = ST_READY;
        end
      end
      default:
      begin
        state_next = ST_READY;
      end
    endcase
  end

  // Presenting the request bin straight away saves a cycle on the RAM read.
  assign b_addr   = (state_reg == ST_READY) ? rd_req_bin : bin_reg;
  assign rd_valid = (state_reg == ST_HOLD);
  assign rd_bin   = bin_reg;
  assign rd_count = count_reg;

  a_response_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (rd_valid && !rd_ready) |=> ($stable(rd_bin) && $stable(rd_count))
  );

endmodule

//--- source/hist_top.sv
`include "hist_config.svh"

module hist_top
(
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              s_valid,
  input  hist_pkg::sample_t s_sample,
  output logic              s_ready,
  input  logic              rd_req_valid,
  input  hist_pkg::bin_t    rd_req_bin,
  output logic              rd_req_ready,
  output logic              rd_valid,
  output hist_pkg::bin_t    rd_bin,
  output hist_pkg::count_t  rd_count,
  input  logic              rd_ready
);

  hist_pkg::bin_t   a_addr;
  hist_pkg::count_t a_wdata;
  logic             a_we;
  hist_pkg::count_t a_rdata;
  hist_pkg::bin_t   b_addr;
  hist_pkg::count_t b_rdata;
  logic             clear_done;

  hist_bin_counter u_counter
  (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_valid    (s_valid),
    .s_sample   (s_sample),
    .s_ready    (s_ready),
    .a_addr     (a_addr),
    .a_wdata    (a_wdata),
    .a_we       (a_we),
    .a_rdata    (a_rdata),
    .clear_done (clear_done)
  );

  hist_dual_port_ram u_ram
  (
    .aclk    (aclk),
    .a_addr  (a_addr),
    .a_wdata (a_wdata),
    .a_we    (a_we),
    .a_rdata (a_rdata),
    .b_addr  (b_addr),
    .b_rdata (b_rdata)
  );

  // The readout stays closed until the clear pass has finished.
  hist_readout u_readout
  (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .clear_done   (clear_done),
    .rd_req_valid (rd_req_valid),
    .rd_req_bin   (rd_req_bin),
    .rd_req_ready (rd_req_ready),
    .b_addr       (b_addr),
    .b_rdata      (b_rdata),
    .rd_valid     (rd_valid),
    .rd_bin       (rd_bin),
    .rd_count     (rd_count),
    .rd_ready     (rd_ready)
  );

endmodule

//--- bench/hist_checker.sv
`include "hist_config.svh"

module hist_checker
(
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              s_valid,
  input  hist_pkg::sample_t s_sample,
  input  logic              s_ready,
  input  logic              rd_req_valid,
  input  hist_pkg::bin_t    rd_req_bin,
  input  logic              rd_req_ready,
  input  logic              rd_valid,
  input  hist_pkg::bin_t    rd_bin,
  input  hist_pkg::count_t  rd_count,
  input  logic              rd_ready,
  input  logic              exp_valid,
  input  hist_pkg::bin_t    exp_bin,
  input  hist_pkg::count_t  exp_count,
  output int                mismatch_count,
  output int                fault_count,
  output int                response_count
);

  localparam int BINS      = 1 << `HIST_ADDR_WIDTH;
  localparam int MAX_COUNT = (1 << `HIST_COUNT_WIDTH) - 1;

  int               model [BINS];
  hist_pkg::bin_t   req_q [$];
  hist_pkg::bin_t   exp_bin_q [$];
  hist_pkg::count_t exp_count_q [$];
  int               clear_cycles;
  logic             ready_seen;
  logic             stalled;
  hist_pkg::bin_t   held_bin;
  hist_pkg::count_t held_count;

  task automatic check_response();
    hist_pkg::bin_t   req_bin;
    hist_pkg::bin_t   file_bin;
    hist_pkg::count_t file_count;
    hist_pkg::count_t want;
    response_count++;
    if (req_q.size() == 0)
    begin
      $display("Response for bin %0d arrived with no request outstanding", rd_bin);
      fault_count++;
    end
    else
    begin
      req_bin = req_q.pop_front();
      if (rd_bin !== req_bin)
      begin
        $display("MISMATCH at %0t: response bin %0d, requested bin %0d", $time, rd_bin, req_bin);
        mismatch_count++;
      end
    end
    want = hist_pkg::count_t'(model[rd_bin]);
    if (rd_count !== want)
    begin
      $display("MISMATCH at %0t: bin %0d read %0d, model has %0d", $time, rd_bin, rd_count, want);
      mismatch_count++;
    end
    if (exp_bin_q.size() == 0)
    begin
      $display("Response for bin %0d has no expected value from the vector file", rd_bin);
      fault_count++;
    end
    else
    begin
      file_bin   = exp_bin_q.pop_front();
      file_count = exp_count_q.pop_front();
      if (rd_bin !== file_bin || rd_count !== file_count)
      begin
        $display("MISMATCH at %0t: bin %0d count %0d, vector file gives bin %0d count %0d",
                 $time, rd_bin, rd_count, file_bin, file_count);
        mismatch_count++;
      end
    end
  endtask

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int b = 0; b < BINS; b++)
      begin
        model[b] = 0;
      end
      req_q.delete();
      exp_bin_q.delete();
      exp_count_q.delete();
      clear_cycles   = 0;
      ready_seen     = 1'b0;
      stalled        = 1'b0;
      mismatch_count = 0;
      fault_count    = 0;
      response_count = 0;
    end
    else
    begin
      // The clear pass must keep the input closed for one cycle per bin.
      if (!ready_seen)
      begin
        if (s_ready)
        begin
          ready_seen = 1'b1;
          if (clear_cycles < BINS)
          begin
            $display("s_ready rose after only %0d cycles of clearing", clear_cycles);
            fault_count++;
          end
        end
        else
        begin
          clear_cycles++;
          if (rd_req_ready)
          begin
            $display("Readout accepted requests before the clear pass finished");
            fault_count++;
          end
          if (rd_valid)
          begin
            $display("rd_valid was high before the clear pass finished");
            fault_count++;
          end
        end
      end
      if (exp_valid)
      begin
        exp_bin_q.push_back(exp_bin);
        exp_count_q.push_back(exp_count);
      end
      if (rd_req_valid && rd_req_ready)
      begin
        req_q.push_back(rd_req_bin);
      end
      if (stalled && !rd_valid)
      begin
        $display("rd_valid dropped before the response was taken");
        fault_count++;
      end
      else if (stalled && (rd_bin !== held_bin || rd_count !== held_count))
      begin
        $display("MISMATCH at %0t: stalled response changed from bin %0d count %0d",
                 $time, held_bin, held_count);
        mismatch_count++;
      end
      stalled    = rd_valid && !rd_ready;
      held_bin   = rd_bin;
      held_count = rd_count;
      if (rd_valid && rd_ready)
      begin
        check_response();
      end
      // Reference histogram that saturates at the largest count.
      if (s_valid && s_ready)
      begin
        if (model[s_sample[`HIST_ADDR_WIDTH-1:0]] < MAX_COUNT)
        begin
          model[s_sample[`HIST_ADDR_WIDTH-1:0]]++;
        end
      end
    end
  end

endmodule

//--- bench/hist_tb.sv
`include "hist_config.svh"

module hist_tb;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int BINS           = 1 << `HIST_ADDR_WIDTH;

  logic              aclk;
  logic              aresetn;
  logic              s_valid;
  hist_pkg::sample_t s_sample;
  logic              s_ready;
  logic              rd_req_valid;
  hist_pkg::bin_t    rd_req_bin;
  logic              rd_req_ready;
  logic              rd_valid;
  hist_pkg::bin_t    rd_bin;
  hist_pkg::count_t  rd_count;
  logic              rd_ready;
  logic              exp_valid;
  hist_pkg::bin_t    exp_bin;
  hist_pkg::count_t  exp_count;
  int                mismatch_count;
  int                fault_count;
  int                response_count;

  logic [31:0]       lcg_state;
  int                tb_errors;
  int                reads_issued;
  logic              timed_out;
  hist_pkg::sample_t push_value_q [$];
  int                push_repeat_q [$];
  hist_pkg::bin_t    read_bin_q [$];
  hist_pkg::count_t  read_count_q [$];

  hist_top UUT (.*);

  hist_checker u_checker (.*);

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Inputs change 10 units after the rising edge.
  task automatic next_cycle();
    @(posedge aclk);
    #10;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    tb_errors++;
    timed_out = 1'b1;
  endtask

  task automatic load_vectors();
    int           fd;
    int           n;
    logic [1023:0] line;
    logic [63:0]  kind;
    logic [31:0]  value;
    int           num;
    fd = $fopen("bench/hist_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open bench/hist_vectors.txt");
      tb_errors++;
    end
    else
    begin
      line = '0;
      while ($fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%s %h %d", kind, value, num);
        if (n == 3 && kind == "P")
        begin
          push_value_q.push_back(hist_pkg::sample_t'(value));
          push_repeat_q.push_back(num);
        end
        else if (n == 3 && kind == "E")
        begin
          read_bin_q.push_back(hist_pkg::bin_t'(value));
          read_count_q.push_back(hist_pkg::count_t'(num));
        end
        line = '0;
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_clear_done();
    int waited;
    waited = 0;
    while (!rd_req_ready && waited < TIMEOUT_CYCLES)
    begin
      next_cycle();
      waited++;
    end
    if (!rd_req_ready)
    begin
      report_timeout("the clear pass to finish");
    end
  endtask

  task automatic push_sample(input hist_pkg::sample_t value);
    logic [31:0] r;
    logic        taken;
    int          waited;
    r = next_random();
    // Occasional idle gap with junk on the sample bus.
    repeat ((r[31:30] == 2'b00) ? int'(r[29:28]) + 1 : 0)
    begin
      s_sample = hist_pkg::sample_t'(next_random());
      next_cycle();
    end
    s_valid  = 1'b1;
    s_sample = value;
    taken    = 1'b0;
    waited   = 0;
    while (!taken && waited < TIMEOUT_CYCLES)
    begin
      taken = s_ready;
      next_cycle();
      waited++;
    end
    s_valid = 1'b0;
    if (!taken)
    begin
      report_timeout("s_ready while a sample was offered");
    end
  endtask

  task automatic read_bin(input hist_pkg::bin_t bin, input hist_pkg::count_t count);
    logic [31:0] r;
    logic        taken;
    int          waited;
    exp_valid = 1'b1;
    exp_bin   = bin;
    exp_count = count;
    next_cycle();
    exp_valid    = 1'b0;
    rd_req_valid = 1'b1;
    rd_req_bin   = bin;
    taken        = 1'b0;
    waited       = 0;
    while (!taken && waited < TIMEOUT_CYCLES)
    begin
      taken = rd_req_ready;
      next_cycle();
      waited++;
    end
    rd_req_valid = 1'b0;
    if (!taken)
    begin
      report_timeout("rd_req_ready");
    end
    else
    begin
      taken  = 1'b0;
      waited = 0;
      // Stall the response about half the time.
      while (!taken && waited < TIMEOUT_CYCLES)
      begin
        r        = next_random();
        rd_ready = r[31];
        taken    = rd_valid && rd_ready;
        next_cycle();
        waited++;
      end
      rd_ready = 1'b0;
      reads_issued++;
      if (!taken)
      begin
        report_timeout("a readout response");
      end
    end
  endtask

  initial
  begin
    aresetn      = 1'b0;
    s_valid      = 1'b0;
    s_sample     = '0;
    rd_req_valid = 1'b0;
    rd_req_bin   = '0;
    rd_ready     = 1'b0;
    exp_valid    = 1'b0;
    exp_bin      = '0;
    exp_count    = '0;
    lcg_state    = 32'h267defa9;
    tb_errors    = 0;
    reads_issued = 0;
    timed_out    = 1'b0;
    load_vectors();
    repeat (2) @(posedge aclk);
    #10;
    aresetn = 1'b1;
    wait_clear_done();
    // Every bin reads zero straight after the clear pass.
    for (int b = 0; b < BINS && !timed_out; b++)
    begin
      read_bin(hist_pkg::bin_t'(b), '0);
    end
    for (int i = 0; i < push_value_q.size() && !timed_out; i++)
    begin
      for (int k = 0; k < push_repeat_q[i] && !timed_out; k++)
      begin
        push_sample(push_value_q[i]);
      end
    end
    repeat (3) next_cycle();
    for (int i = 0; i < read_bin_q.size() && !timed_out; i++)
    begin
      read_bin(read_bin_q[i], read_count_q[i]);
    end
    repeat (2) next_cycle();
    if (read_bin_q.size() == 0)
    begin
      $display("The vector file holds no expected counts");
      tb_errors++;
    end
    if (response_count != reads_issued)
    begin
      $display("Checker saw %0d responses for %0d reads", response_count, reads_issued);
      tb_errors++;
    end
    $display("Errors: %0d mismatches, %0d checker faults, %0d testbench errors",
             mismatch_count, fault_count, tb_errors);
    if (mismatch_count == 0 && fault_count == 0 && tb_errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hist_subsys.f
+incdir+source
source/hist_pkg.sv
source/hist_bin_counter.sv
source/hist_dual_port_ram.sv
source/hist_readout.sv
source/hist_top.sv
bench/hist_checker.sv
bench/hist_tb.sv

//--- Makefile
# Verilator build and run of the histogram testbench.
VERILATOR ?= verilator
TOP       ?= hist_tb
FILELIST  ?= hist_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/hist_vectors.txt
# P sample_hex repeat_dec : push the sample that many times
# E bin_hex count_dec     : expected count of that bin after all pushes
P 0003 5
P a103 4
P 0000 2
P fff0 1
P 0007 200
P 1237 100
P 000c 10
P 800c 1
P 0005 1
P 0125 3
P 00ff 6
P 4a8a 20
P 0001 255
P 0002 254
P 3332 2
E 0 3
E 1 255
E 2 255
E 3 9
E 4 0
E 5 4
E 6 0
E 7 255
E 8 0
E 9 0
E a 20
E b 0
E c 11
E d 0
E e 0
E f 6
